/* verification/sad_input.txt */
# block: name / ref0..ref7 / threshold multiple_triggers active sample_count
# then samples (n = LCG noise) / expected trigger count, first trigger index (-1 none)
exact_match
10 20 30 5 0 35 15 25
0 0 1 24
n n n n n n n n n n
10 20 30 5 0 35 15 25
n n n n n n
1 17
threshold_boundary
10 10 10 10 10 10 10 10
40 1 1 29
n n n n
15 15 15 15 15 15 15 15
n n n n
15 15 15 15 15 15 15 16
n n n n n
1 11
single_shot
1 2 3 4 5 6 7 8
3 0 1 27
n n n
1 2 3 4 5 6 7 8
n n n
1 2 3 4 5 6 7 8
n n n n n
1 10
multiple_triggers
1 2 3 4 5 6 7 8
3 1 1 27
n n n
1 2 3 4 5 6 7 8
n n n
1 2 3 4 5 6 7 8
n n n n n
2 10
inactive
10 20 30 5 0 35 15 25
0 0 0 24
n n n n n n n n n n
10 20 30 5 0 35 15 25
n n n n n n
0 -1

/* vlog.f */
+incdir+include
hw/sad_pipe_pkg.sv
hw/sad_reg_pkg.sv
hw/sad_regs.sv
hw/sad_window.sv
hw/sad_absdiff.sv
hw/sad_sum_compare.sv
hw/sad_control.sv
hw/sad_top.sv
verification/sad_clkgen.sv
verification/sad_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sad_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f vlog.f

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif ! grep -q "all tests passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/sad_tb.sv */
`timescale 1ns/1ns
`include "sad_defs.svh"

module sad_tb import sad_reg_pkg::*; ();

    logic       adc_sampleclk;
    logic       reset;
    logic [7:0] adc_datain;
    logic       armed_and_ready;
    logic       active;
    reg_addr_t  reg_address;
    logic [2:0] reg_bytecnt;
    logic [7:0] reg_datai;
    logic [7:0] reg_datao;
    logic       reg_read;
    logic       reg_write;
    logic       trigger;

    int    fd;
    int    lcg_state = 71;
    int    cycles = 0;
    int    limit = 100;  // reset and id checks
    int    test_errors;
    int    tests_run = 0;
    int    tests_failed = 0;

    // current test block
    string name;
    int    refs[8];
    int    thr;
    int    multi;
    int    act;
    int    n;
    int    exp_count;
    int    exp_first;
    int    samples[$];

    sad_clkgen sad_clkgen_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset)
    );

    sad_top sad_top_i (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .reg_address     (reg_address),
        .reg_bytecnt     (reg_bytecnt),
        .reg_datai       (reg_datai),
        .reg_datao       (reg_datao),
        .reg_read        (reg_read),
        .reg_write       (reg_write),
        .trigger         (trigger)
    );

    always @(posedge adc_sampleclk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // noise stays in 200..255 far above any reference byte
    function automatic int lcg_noise();
        lcg_state = (lcg_state * 1103515245 + 12345) & 32'h7fffffff;
        return 200 + ((lcg_state >>> 16) % 56);
    endfunction

    task automatic check(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR %s: expected %0d, actual %0d", what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input int bytecnt, input int data);
        @(negedge adc_sampleclk);
        reg_address = reg_addr_t'(addr);
        reg_bytecnt = bytecnt[2:0];
        reg_datai   = data[7:0];
        reg_write   = 1'b1;
        @(negedge adc_sampleclk);
        reg_write   = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, input int bytecnt, output int data);
        @(negedge adc_sampleclk);
        reg_address = reg_addr_t'(addr);
        reg_bytecnt = bytecnt[2:0];
        reg_read    = 1'b1;
        #5 data = reg_datao;  // sampled mid low phase
        @(negedge adc_sampleclk);
        reg_read    = 1'b0;
    endtask

    // next token of the data file skipping comment lines
    task automatic next_word(output string w);
        string line;
        int    r;
        w = "";
        forever begin
            r = $fscanf(fd, "%s", w);
            if (r != 1) begin
                w = "";
                return;
            end
            if (w.substr(0, 0) != "#") return;
            r = $fgets(line, fd);
        end
    endtask

    task automatic read_int(output int v);
        string w;
        next_word(w);
        v = w.atoi();
    endtask

    task automatic read_test();
        string w;
        for (int m = 0; m < 8; m++) read_int(refs[m]);
        read_int(thr);
        read_int(multi);
        read_int(act);
        read_int(n);
        samples.delete();
        for (int i = 0; i < n; i++) begin
            next_word(w);
            if (w == "n") samples.push_back(lcg_noise());
            else samples.push_back(w.atoi());
        end
        read_int(exp_count);
        read_int(exp_first);
    endtask

    task automatic report(input string what);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", what);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", what, test_errors);
        end
    endtask

    task automatic run_test();
        int pred[$];
        int seen[$];
        int sad;
        int d;
        int rd;
        test_errors = 0;
        limit = limit + n + 200;

        // window ending at sample j lines up sample j-7 with ref byte 0
        if (act != 0) begin
            for (int j = 7; j < n; j++) begin
                sad = 0;
                for (int m = 0; m < 8; m++) begin
                    d = samples[j-7+m] - refs[m];
                    sad += (d < 0) ? -d : d;
                end
                if (sad <= thr) begin
                    pred.push_back(j);
                    if (multi == 0) break;
                end
            end
        end
        check({name, " model count"}, exp_count, pred.size());
        check({name, " model first"}, exp_first, (pred.size() > 0) ? pred[0] : -1);

        for (int m = 0; m < 8; m++) write_reg(`SAD_ADDR_REFERENCE, m, refs[m]);
        write_reg(`SAD_ADDR_THRESHOLD, 0, thr & 8'hff);
        write_reg(`SAD_ADDR_THRESHOLD, 1, thr >> 8);
        write_reg(`SAD_ADDR_MULTIPLE_TRIGGERS, 0, multi);
        for (int m = 0; m < 8; m++) begin
            read_reg(`SAD_ADDR_REFERENCE, m, rd);
            check({name, " reference readback"}, refs[m], rd);
        end
        read_reg(`SAD_ADDR_THRESHOLD, 0, rd);
        check({name, " threshold low"}, thr & 8'hff, rd);
        read_reg(`SAD_ADDR_THRESHOLD, 1, rd);
        check({name, " threshold high"}, thr >> 8, rd);
        read_reg(`SAD_ADDR_MULTIPLE_TRIGGERS, 0, rd);
        check({name, " multiple triggers readback"}, multi, rd);

        // sample j is captured at edge j and its trigger shows at negedge j+5
        for (int k = 0; k < n + 6; k++) begin
            @(negedge adc_sampleclk);
            if (trigger) seen.push_back(k - 5);
            adc_datain = (k < n) ? samples[k][7:0] : 8'(lcg_noise());
            if (k == 0) active = (act != 0);
        end
        @(negedge adc_sampleclk);
        active = 1'b0;

        check({name, " trigger count"}, pred.size(), seen.size());
        for (int i = 0; i < pred.size() && i < seen.size(); i++) begin
            check({name, " trigger index"}, pred[i], seen[i]);
        end
        read_reg(`SAD_ADDR_STATUS, 0, rd);
        check({name, " status"}, (pred.size() > 0) ? 1 : 0, rd);

        // status write clears triggered and re-arms the FSM
        write_reg(`SAD_ADDR_STATUS, 0, 0);
        repeat (2) @(negedge adc_sampleclk);
        read_reg(`SAD_ADDR_STATUS, 0, rd);
        check({name, " status cleared"}, 0, rd);
        report(name);
    endtask

    initial begin
        int rd;
        adc_datain      = 8'h00;
        armed_and_ready = 1'b0;
        active          = 1'b0;
        reg_address     = addr_reference;
        reg_bytecnt     = 3'd0;
        reg_datai       = 8'h00;
        reg_read        = 1'b0;
        reg_write       = 1'b0;

        fd = $fopen("verification/sad_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus data file");
            $display("tests failed");
            $finish;
        end else begin
            @(negedge reset);
            test_errors = 0;
            check("reset trigger", 0, trigger);
            read_reg(`SAD_ADDR_STATUS, 0, rd);
            check("reset status", 0, rd);
            read_reg(`SAD_ADDR_BITS_PER_SAMPLE, 0, rd);
            check("bits per sample", 8, rd);
            read_reg(`SAD_ADDR_REF_SAMPLES, 0, rd);
            check("ref samples", 8, rd);
            // upper threshold byte holds bits 10:8
            write_reg(`SAD_ADDR_THRESHOLD, 1, 8'h05);
            read_reg(`SAD_ADDR_THRESHOLD, 1, rd);
            check("threshold high byte", 5, rd);
            report("reset_and_ids");
            armed_and_ready = 1'b1;  // stays armed so re-arming goes through status writes

            next_word(name);
            while (name != "") begin
                read_test();
                run_test();
                next_word(name);
            end
            $fclose(fd);

            $display("%0d tests run, %0d failed", tests_run, tests_failed);
            if (tests_failed == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

/* verification/sad_clkgen.sv */
`timescale 1ns/1ns

module sad_clkgen (
    output logic adc_sampleclk,
    output logic reset
);

    initial begin
        adc_sampleclk = 1'b0;
        forever #20 adc_sampleclk = ~adc_sampleclk; // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge adc_sampleclk);
        @(negedge adc_sampleclk) reset = 1'b0;
    end

endmodule

/* hw/sad_top.sv */
`timescale 1ns/1ns
`include "sad_defs.svh"

module sad_top import sad_pipe_pkg::*, sad_reg_pkg::*; (
    input  logic       adc_sampleclk,
    input  logic       reset,
    input  sample_t    adc_datain,
    input  logic       armed_and_ready,
    input  logic       active,
    input  reg_addr_t  reg_address,
    input  logic [2:0] reg_bytecnt,
    input  logic [7:0] reg_datai,
    output logic [7:0] reg_datao,
    input  logic       reg_read,
    input  logic       reg_write,
    output logic       trigger
);

    sad_config_t cfg;
    logic        status_clear;
    logic        triggered;
    logic        window_run;
    window_t     window;
    diff_t       diff;
    logic        match;

    sad_regs sad_regs_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .reg_address   (reg_address),
        .reg_bytecnt   (reg_bytecnt),
        .reg_datai     (reg_datai),
        .reg_read      (reg_read),
        .reg_write     (reg_write),
        .triggered     (triggered),
        .reg_datao     (reg_datao),
        .cfg           (cfg),
        .status_clear  (status_clear)
    );

    // window -> absdiff -> sum -> match, one register each
    sad_window sad_window_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .window_run    (window_run),
        .adc_datain    (adc_datain),
        .window        (window)
    );

    sad_absdiff sad_absdiff_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .window        (window),
        .reference     (cfg.reference),
        .diff          (diff)
    );

    sad_sum_compare sad_sum_compare_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .diff          (diff),
        .threshold     (cfg.threshold),
        .match         (match)
    );

    sad_control sad_control_i (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .armed_and_ready   (armed_and_ready),
        .active            (active),
        .match             (match),
        .multiple_triggers (cfg.multiple_triggers),
        .status_clear      (status_clear),
        .window_run        (window_run),
        .trigger           (trigger),
        .triggered         (triggered)
    );

endmodule

/* hw/sad_control.sv */
`timescale 1ns/1ns
`include "sad_defs.svh"

module sad_control import sad_pipe_pkg::*; (
    input  logic adc_sampleclk,
    input  logic reset,
    input  logic armed_and_ready,
    input  logic active,
    input  logic match,
    input  logic multiple_triggers,
    input  logic status_clear,
    output logic window_run,
    output logic trigger,
    output logic triggered
);

    ctrl_state_t state;
    logic        searching;
    logic        fire;

    assign searching = (state == st_filling) || (state == st_running);

    // match only comes out of the last stage with a valid window behind it
    assign fire = searching && match && armed_and_ready && active;

    // high already in idle so the edge leaving idle captures sample 0
    assign window_run = (state == st_idle) ? (armed_and_ready && active) : searching;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state     <= st_idle;
            trigger   <= 1'b0;
            triggered <= 1'b0;
        end else begin
            trigger <= fire;  // one cycle pulse per match

            if (status_clear) begin
                triggered <= 1'b0;
            end else if (fire) begin
                triggered <= 1'b1;
            end

            case (state)
                st_idle: begin
                    if (armed_and_ready && active) begin
                        state <= st_filling;
                    end
                end
                st_filling, st_running: begin
                    if (!active) begin
                        state <= st_done;
                    end else if (fire && !multiple_triggers) begin
                        state <= st_done;  // single shot per arming
                    end else if (match) begin
                        state <= st_running;  // pipeline primed
                    end
                end
                st_done: begin
                    // wait for disarm or a status write before re-arming
                    if (!armed_and_ready || status_clear) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* hw/sad_sum_compare.sv */
`timescale 1ns/1ns
`include "sad_defs.svh"

module sad_sum_compare import sad_pipe_pkg::*; (
    input  logic                      adc_sampleclk,
    input  logic                      reset,
    input  diff_t                     diff,
    input  logic [`SAD_SUM_WIDTH-1:0] threshold,
    output logic                      match
);

    logic [`SAD_SUM_WIDTH-1:0] tree_sum;
    sum_t                      sum_r;

    // adder tree, left to the synthesis tool to balance
    always_comb begin
        tree_sum = '0;
        for (int k = 0; k < `SAD_REF_SAMPLES; k++) begin
            tree_sum = tree_sum + `SAD_SUM_WIDTH'(diff.absdiff[k]);
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        sum_r.sum <= tree_sum;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            sum_r.valid <= 1'b0;
        end else begin
            sum_r.valid <= diff.valid;
        end
    end

    // inclusive compare, a sum equal to the threshold still matches
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            match <= 1'b0;
        end else begin
            match <= sum_r.valid && (sum_r.sum <= threshold);
        end
    end

endmodule

/* hw/sad_absdiff.sv */
`timescale 1ns/1ns
`include "sad_defs.svh"

module sad_absdiff import sad_pipe_pkg::*; (
    input  logic                                             adc_sampleclk,
    input  logic                                             reset,
    input  window_t                                          window,
    input  logic [`SAD_REF_SAMPLES*`SAD_BITS_PER_SAMPLE-1:0] reference,
    output diff_t                                            diff
);

    sample_t ref_sample [`SAD_REF_SAMPLES];

    always_comb begin
        for (int k = 0; k < `SAD_REF_SAMPLES; k++) begin
            ref_sample[k] = reference[k*`SAD_BITS_PER_SAMPLE +: `SAD_BITS_PER_SAMPLE];
        end
    end

    // one subtractor per slot, larger minus smaller
    always_ff @(posedge adc_sampleclk) begin
        for (int k = 0; k < `SAD_REF_SAMPLES; k++) begin
            if (window.samples[k] > ref_sample[k]) begin
                diff.absdiff[k] <= window.samples[k] - ref_sample[k];
            end else begin
                diff.absdiff[k] <= ref_sample[k] - window.samples[k];
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            diff.valid <= 1'b0;
        end else begin
            diff.valid <= window.valid;
        end
    end

endmodule

/* hw/sad_window.sv */
`timescale 1ns/1ns
`include "sad_defs.svh"

module sad_window import sad_pipe_pkg::*; (
    input  logic    adc_sampleclk,
    input  logic    reset,
    input  logic    window_run,
    input  sample_t adc_datain,
    output window_t window
);

    localparam int fill_w = $clog2(`SAD_REF_SAMPLES + 1);

    logic [fill_w-1:0] fill;  // samples captured since window_run rose, saturates

    // sample history, newest enters at the top slot
    always_ff @(posedge adc_sampleclk) begin
        if (window_run) begin
            window.samples <= {adc_datain, window.samples[`SAD_REF_SAMPLES-1:1]};
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            fill         <= '0;
            window.valid <= 1'b0;
        end else if (window_run) begin
            if (fill != fill_w'(`SAD_REF_SAMPLES)) begin
                fill <= fill + 1'b1;
            end
            // this capture completes a window once 7 or more came before it
            window.valid <= (fill >= fill_w'(`SAD_REF_SAMPLES - 1));
        end else begin
            fill         <= '0;
            window.valid <= 1'b0;
        end
    end

endmodule

/* hw/sad_regs.sv */
`timescale 1ns/1ns
`include "sad_defs.svh"

module sad_regs import sad_reg_pkg::*; (
    input  logic        adc_sampleclk,
    input  logic        reset,
    input  reg_addr_t   reg_address,
    input  logic [2:0]  reg_bytecnt,
    input  logic [7:0]  reg_datai,
    input  logic        reg_read,
    input  logic        reg_write,
    input  logic        triggered,
    output logic [7:0]  reg_datao,
    output sad_config_t cfg,
    output logic        status_clear
);

    localparam int thr_sel_w = $clog2(`SAD_THRESHOLD_BYTES);

    logic [8*`SAD_THRESHOLD_BYTES-1:0] thr_bytes;  // threshold as a byte array
    logic [8*`SAD_THRESHOLD_BYTES-1:0] thr_next;
    logic [thr_sel_w-1:0]              thr_sel;
    logic                              thr_byte_ok;

    assign thr_bytes   = (8*`SAD_THRESHOLD_BYTES)'(cfg.threshold);
    assign thr_sel     = reg_bytecnt[thr_sel_w-1:0];
    assign thr_byte_ok = (reg_bytecnt < `SAD_THRESHOLD_BYTES);

    // merge the incoming byte into the little-endian threshold
    always_comb begin
        thr_next = thr_bytes;
        thr_next[thr_sel*8 +: 8] = reg_datai;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            cfg          <= '0;
            status_clear <= 1'b0;
        end else begin
            status_clear <= reg_write && (reg_address == addr_status);
            if (reg_write) begin
                case (reg_address)
                    addr_reference:
                        cfg.reference[reg_bytecnt*8 +: 8] <= reg_datai;
                    addr_threshold: begin
                        if (thr_byte_ok) begin
                            cfg.threshold <= thr_next[`SAD_SUM_WIDTH-1:0]; // upper bits dropped
                        end
                    end
                    addr_multiple_triggers:
                        cfg.multiple_triggers <= reg_datai[0];
                    default: ;
                endcase
            end
        end
    end

    // read data is only driven while reg_read is high
    always_comb begin
        reg_datao = 8'h00;
        if (reg_read) begin
            case (reg_address)
                addr_reference:         reg_datao = cfg.reference[reg_bytecnt*8 +: 8];
                addr_threshold: begin
                    if (thr_byte_ok) begin
                        reg_datao = thr_bytes[thr_sel*8 +: 8];
                    end
                end
                addr_status:            reg_datao = {7'b0, triggered};
                addr_bits_per_sample:   reg_datao = 8'(`SAD_BITS_PER_SAMPLE);
                addr_ref_samples:       reg_datao = 8'(`SAD_REF_SAMPLES);
                addr_multiple_triggers: reg_datao = {7'b0, cfg.multiple_triggers};
                default:                reg_datao = 8'h00;
            endcase
        end
    end

endmodule

/* hw/sad_reg_pkg.sv */
`include "sad_defs.svh"

package sad_reg_pkg;

    typedef enum logic [7:0] {
        addr_reference         = `SAD_ADDR_REFERENCE,
        addr_threshold         = `SAD_ADDR_THRESHOLD,
        addr_status            = `SAD_ADDR_STATUS,
        addr_bits_per_sample   = `SAD_ADDR_BITS_PER_SAMPLE,
        addr_ref_samples       = `SAD_ADDR_REF_SAMPLES,
        addr_multiple_triggers = `SAD_ADDR_MULTIPLE_TRIGGERS
    } reg_addr_t;

    // everything the pipeline needs from the register file
    typedef struct packed {
        logic [`SAD_REF_SAMPLES*`SAD_BITS_PER_SAMPLE-1:0] reference; // byte k = sample k
        logic [`SAD_SUM_WIDTH-1:0]                        threshold;
        logic                                             multiple_triggers;
    } sad_config_t;

endpackage

/* hw/sad_pipe_pkg.sv */
`include "sad_defs.svh"

package sad_pipe_pkg;

    typedef logic [`SAD_BITS_PER_SAMPLE-1:0] sample_t;

    // samples[0] is the oldest sample, compared against reference byte 0
    typedef struct packed {
        logic                              valid;
        sample_t [`SAD_REF_SAMPLES-1:0]    samples;
    } window_t;

    // per-sample absolute differences, same ordering as window_t
    typedef struct packed {
        logic                              valid;
        sample_t [`SAD_REF_SAMPLES-1:0]    absdiff;
    } diff_t;

    typedef struct packed {
        logic                              valid;
        logic [`SAD_SUM_WIDTH-1:0]         sum;
    } sum_t;

    // arming FSM
    typedef enum logic [1:0] {
        st_idle,
        st_filling,
        st_running,
        st_done
    } ctrl_state_t;

endpackage

/* include/sad_defs.svh */
`ifndef SAD_DEFS_SVH
`define SAD_DEFS_SVH

// window geometry
`define SAD_REF_SAMPLES      8
`define SAD_BITS_PER_SAMPLE  8

// holds SAD_REF_SAMPLES * (2**SAD_BITS_PER_SAMPLE - 1)
`define SAD_SUM_WIDTH        11
`define SAD_THRESHOLD_BYTES  2

// register map
`define SAD_ADDR_REFERENCE          8'h00
`define SAD_ADDR_THRESHOLD          8'h01
`define SAD_ADDR_STATUS             8'h02
`define SAD_ADDR_BITS_PER_SAMPLE    8'h03
`define SAD_ADDR_REF_SAMPLES        8'h04
`define SAD_ADDR_MULTIPLE_TRIGGERS  8'h05

`endif
